/* Bender.yml */
package:
  name: camera

sources:
  - logic/camera_pkg.sv
  - logic/camera_regs.sv
  - logic/pixel_crop.sv
  - logic/color_metering.sv
  - logic/frame_capture.sv
  - logic/image_buffer.sv
  - logic/command_decoder.sv
  - logic/camera.sv
  - target: simulation
    files:
      - verification/camera_tb.sv

/* logic/camera.sv */
// Top level of the still-capture path, instances and wiring only
// Parameters given here set crop reset values, buffer depth and metering window
`timescale 1ns/1ps

module camera import camera_pkg::*; #(
    parameter logic [X_WIDTH-1:0] CROP_X_START_RESET = '0,
    parameter logic [X_WIDTH-1:0] CROP_X_END_RESET = 11'd1280,
    parameter logic [Y_WIDTH-1:0] CROP_Y_START_RESET = '0,
    parameter logic [Y_WIDTH-1:0] CROP_Y_END_RESET = 10'd720,
    parameter int                 BUFFER_WORDS = 16384,
    parameter logic [X_WIDTH-1:0] METER_X_START = 11'd384,
    parameter logic [Y_WIDTH-1:0] METER_Y_START = 10'd104,
    parameter int                 METER_SIZE_LOG2 = 9
) (
    input  logic                   clock_spi_in,
    input  logic                   mipi_byte_reset_n,
    input  logic                   frame_valid_i,
    input  logic                   line_valid_i,
    input  logic [PIXEL_WIDTH-1:0] pixel_data_i,
    input  logic [7:0]             op_code_i,
    input  logic                   op_code_valid_i,
    input  logic [7:0]             operand_i,
    input  logic                   operand_valid_i,
    input  int                     operand_count_i,
    output logic [7:0]             response_o,
    output logic                   response_valid_o
);

    localparam int ADDR_WIDTH = $clog2(BUFFER_WORDS);

    logic [X_WIDTH-1:0] crop_x_start, crop_x_end;
    logic [Y_WIDTH-1:0] crop_y_start, crop_y_end;
    logic [PIXEL_WIDTH-1:0] crop_pixel;
    logic crop_pixel_valid, crop_frame_valid;
    logic capture_request, capture_busy, capture_done;
    logic write_enable;
    logic [ADDR_WIDTH-1:0] write_address;
    logic [31:0] write_data;
    logic [ADDR_WIDTH+1:0] read_address;  // Byte address
    logic [7:0] read_byte;
    logic [7:0] red_level, green_level, blue_level;

    camera_regs #(
        .CROP_X_START_RESET(CROP_X_START_RESET),
        .CROP_X_END_RESET(CROP_X_END_RESET),
        .CROP_Y_START_RESET(CROP_Y_START_RESET),
        .CROP_Y_END_RESET(CROP_Y_END_RESET)
    ) camera_regs (
        .clock_spi_in(clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .op_code_i(op_code_i),
        .op_code_valid_i(op_code_valid_i),
        .operand_i(operand_i),
        .operand_valid_i(operand_valid_i),
        .operand_count_i(operand_count_i),
        .frame_valid_i(frame_valid_i),
        .crop_x_start_o(crop_x_start),
        .crop_x_end_o(crop_x_end),
        .crop_y_start_o(crop_y_start),
        .crop_y_end_o(crop_y_end)
    );

    pixel_crop pixel_crop (
        .clock_spi_in(clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .pixel_data_i(pixel_data_i),
        .line_valid_i(line_valid_i),
        .frame_valid_i(frame_valid_i),
        .crop_x_start_i(crop_x_start),
        .crop_x_end_i(crop_x_end),
        .crop_y_start_i(crop_y_start),
        .crop_y_end_i(crop_y_end),
        .pixel_o(crop_pixel),
        .pixel_valid_o(crop_pixel_valid),
        .frame_valid_o(crop_frame_valid)
    );

    // Metering sees the raw stream, not the crop
    color_metering #(
        .METER_X_START(METER_X_START),
        .METER_Y_START(METER_Y_START),
        .METER_SIZE_LOG2(METER_SIZE_LOG2)
    ) color_metering (
        .clock_spi_in(clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .pixel_data_i(pixel_data_i),
        .line_valid_i(line_valid_i),
        .frame_valid_i(frame_valid_i),
        .red_level_o(red_level),
        .green_level_o(green_level),
        .blue_level_o(blue_level)
    );

    frame_capture #(
        .BUFFER_WORDS(BUFFER_WORDS)
    ) frame_capture (
        .clock_spi_in(clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .capture_request_i(capture_request),
        .pixel_i(crop_pixel),
        .pixel_valid_i(crop_pixel_valid),
        .frame_valid_i(crop_frame_valid),
        .capture_busy_o(capture_busy),
        .capture_done_o(capture_done),
        .write_enable_o(write_enable),
        .write_address_o(write_address),
        .write_data_o(write_data)
    );

    image_buffer #(
        .BUFFER_WORDS(BUFFER_WORDS)
    ) image_buffer (
        .clock_spi_in(clock_spi_in),
        .write_enable_i(write_enable),
        .write_address_i(write_address),
        .write_data_i(write_data),
        .read_address_i(read_address),
        .read_byte_o(read_byte)
    );

    command_decoder #(
        .BUFFER_WORDS(BUFFER_WORDS)
    ) command_decoder (
        .clock_spi_in(clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .op_code_i(op_code_i),
        .op_code_valid_i(op_code_valid_i),
        .operand_valid_i(operand_valid_i),
        .operand_count_i(operand_count_i),
        .capture_busy_i(capture_busy),
        .capture_done_i(capture_done),
        .read_byte_i(read_byte),
        .red_level_i(red_level),
        .green_level_i(green_level),
        .blue_level_i(blue_level),
        .capture_request_o(capture_request),
        .read_address_o(read_address),
        .response_o(response_o),
        .response_valid_o(response_valid_o)
    );

endmodule

/* logic/camera_pkg.sv */
// Constants shared by the still-capture RTL and its testbench
// Pixel and position widths, host op-codes and status bit positions
package camera_pkg;

    localparam int PIXEL_WIDTH = 10;  // Raw Bayer sample
    localparam int X_WIDTH = 11;      // Column counter
    localparam int Y_WIDTH = 10;      // Line counter

    // Capture and readback commands
    localparam logic [7:0] OP_CAPTURE = 8'h20;
    localparam logic [7:0] OP_STATUS = 8'h21;
    localparam logic [7:0] OP_READ = 8'h22;
    localparam logic [7:0] OP_METERING = 8'h25;

    // Crop window writes take operand 0 as low byte and operand 1 as high byte
    localparam logic [7:0] OP_CROP_X_START = 8'h40;
    localparam logic [7:0] OP_CROP_X_END = 8'h41;
    localparam logic [7:0] OP_CROP_Y_START = 8'h42;
    localparam logic [7:0] OP_CROP_Y_END = 8'h43;

    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;

endpackage

/* logic/camera_regs.sv */
// Crop window registers written by the host over the op-code interface
// Writes land in a shadow copy, which is loaded between frames
`timescale 1ns/1ps

module camera_regs import camera_pkg::*; #(
    parameter logic [X_WIDTH-1:0] CROP_X_START_RESET = '0,
    parameter logic [X_WIDTH-1:0] CROP_X_END_RESET = 11'd1280,
    parameter logic [Y_WIDTH-1:0] CROP_Y_START_RESET = '0,
    parameter logic [Y_WIDTH-1:0] CROP_Y_END_RESET = 10'd720
) (
    input  logic               clock_spi_in,
    input  logic               mipi_byte_reset_n,
    input  logic [7:0]         op_code_i,
    input  logic               op_code_valid_i,
    input  logic [7:0]         operand_i,
    input  logic               operand_valid_i,
    input  int                 operand_count_i,
    input  logic               frame_valid_i,
    output logic [X_WIDTH-1:0] crop_x_start_o,
    output logic [X_WIDTH-1:0] crop_x_end_o,
    output logic [Y_WIDTH-1:0] crop_y_start_o,
    output logic [Y_WIDTH-1:0] crop_y_end_o
);

    logic [X_WIDTH-1:0] x_start_q, x_end_q;
    logic [Y_WIDTH-1:0] y_start_q, y_end_q;
    logic operand_valid_q;
    logic write_low, write_high;

    assign write_low = op_code_valid_i && operand_valid_i && !operand_valid_q
                       && operand_count_i == 0;
    assign write_high = op_code_valid_i && operand_valid_i && !operand_valid_q
                        && operand_count_i == 1;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            operand_valid_q <= 1'b0;
            x_start_q <= CROP_X_START_RESET;
            x_end_q <= CROP_X_END_RESET;
            y_start_q <= CROP_Y_START_RESET;
            y_end_q <= CROP_Y_END_RESET;
            crop_x_start_o <= CROP_X_START_RESET;
            crop_x_end_o <= CROP_X_END_RESET;
            crop_y_start_o <= CROP_Y_START_RESET;
            crop_y_end_o <= CROP_Y_END_RESET;
        end else begin
            operand_valid_q <= operand_valid_i;
            case (op_code_i)
                OP_CROP_X_START: begin
                    if (write_low) x_start_q[7:0] <= operand_i;
                    if (write_high) x_start_q[X_WIDTH-1:8] <= operand_i[X_WIDTH-9:0];
                end
                OP_CROP_X_END: begin
                    if (write_low) x_end_q[7:0] <= operand_i;
                    if (write_high) x_end_q[X_WIDTH-1:8] <= operand_i[X_WIDTH-9:0];
                end
                OP_CROP_Y_START: begin
                    if (write_low) y_start_q[7:0] <= operand_i;
                    if (write_high) y_start_q[Y_WIDTH-1:8] <= operand_i[Y_WIDTH-9:0];
                end
                OP_CROP_Y_END: begin
                    if (write_low) y_end_q[7:0] <= operand_i;
                    if (write_high) y_end_q[Y_WIDTH-1:8] <= operand_i[Y_WIDTH-9:0];
                end
                default: ;
            endcase
            if (!frame_valid_i) begin  // Only load between frames
                crop_x_start_o <= x_start_q;
                crop_x_end_o <= x_end_q;
                crop_y_start_o <= y_start_q;
                crop_y_end_o <= y_end_q;
            end
        end
    end

endmodule

/* logic/color_metering.sv */
// Average red, green and blue level of the raw RGGB stream in a square window
// Sums are taken over one frame and turned into levels when the frame ends
`timescale 1ns/1ps

module color_metering import camera_pkg::*; #(
    parameter logic [X_WIDTH-1:0] METER_X_START = 11'd384,
    parameter logic [Y_WIDTH-1:0] METER_Y_START = 10'd104,
    parameter int                 METER_SIZE_LOG2 = 9
) (
    input  logic                   clock_spi_in,
    input  logic                   mipi_byte_reset_n,
    input  logic [PIXEL_WIDTH-1:0] pixel_data_i,
    input  logic                   line_valid_i,
    input  logic                   frame_valid_i,
    output logic [7:0]             red_level_o,
    output logic [7:0]             green_level_o,
    output logic [7:0]             blue_level_o
);

    localparam int SUM_WIDTH = 8 + 2 * METER_SIZE_LOG2;
    localparam int RB_SHIFT = 2 * METER_SIZE_LOG2 - 2;  // Quarter of the sites
    localparam int G_SHIFT = 2 * METER_SIZE_LOG2 - 1;   // Half of the sites
    localparam int X_END = METER_X_START + (1 << METER_SIZE_LOG2);
    localparam int Y_END = METER_Y_START + (1 << METER_SIZE_LOG2);

    logic [X_WIDTH-1:0] x_count;
    logic [Y_WIDTH-1:0] y_count;
    logic line_valid_q, frame_valid_q;
    logic [SUM_WIDTH-1:0] red_sum, green_sum, blue_sum;
    logic [SUM_WIDTH-1:0] red_avg, green_avg, blue_avg;
    logic [7:0] sample;
    logic metered;

    assign sample = pixel_data_i[PIXEL_WIDTH-1 -: 8];
    assign metered = frame_valid_i && line_valid_i
                     && x_count >= METER_X_START && x_count < X_END
                     && y_count >= METER_Y_START && y_count < Y_END;
    assign red_avg = red_sum >> RB_SHIFT;
    assign green_avg = green_sum >> G_SHIFT;
    assign blue_avg = blue_sum >> RB_SHIFT;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count <= '0;
            y_count <= '0;
            line_valid_q <= 1'b0;
            frame_valid_q <= 1'b0;
            red_sum <= '0;
            green_sum <= '0;
            blue_sum <= '0;
            red_level_o <= '0;
            green_level_o <= '0;
            blue_level_o <= '0;
        end else begin
            line_valid_q <= line_valid_i;
            frame_valid_q <= frame_valid_i;

            if (!line_valid_i) x_count <= '0;
            else if (frame_valid_i) x_count <= x_count + 1'b1;
            if (!frame_valid_i) y_count <= '0;
            else if (line_valid_q && !line_valid_i) y_count <= y_count + 1'b1;

            if (frame_valid_q && !frame_valid_i) begin  // Frame end
                red_level_o <= red_avg[7:0];
                green_level_o <= green_avg[7:0];
                blue_level_o <= blue_avg[7:0];
                red_sum <= '0;
                green_sum <= '0;
                blue_sum <= '0;
            end else if (metered) begin
                case ({y_count[0], x_count[0]})
                    2'b00: red_sum <= red_sum + sample;
                    2'b11: blue_sum <= blue_sum + sample;
                    default: green_sum <= green_sum + sample;
                endcase
            end
        end
    end

endmodule

/* logic/command_decoder.sv */
// Host command handling for capture, status, image readback and metering
// Responses are registered and flagged valid while a read-type op-code is held
`timescale 1ns/1ps

module command_decoder import camera_pkg::*; #(
    parameter int BUFFER_WORDS = 16384,
    localparam int ADDR_WIDTH = $clog2(BUFFER_WORDS)
) (
    input  logic                  clock_spi_in,
    input  logic                  mipi_byte_reset_n,
    input  logic [7:0]            op_code_i,
    input  logic                  op_code_valid_i,
    input  logic                  operand_valid_i,
    input  int                    operand_count_i,
    input  logic                  capture_busy_i,
    input  logic                  capture_done_i,
    input  logic [7:0]            read_byte_i,
    input  logic [7:0]            red_level_i,
    input  logic [7:0]            green_level_i,
    input  logic [7:0]            blue_level_i,
    output logic                  capture_request_o,
    output logic [ADDR_WIDTH+1:0] read_address_o,
    output logic [7:0]            response_o,
    output logic                  response_valid_o
);

    logic op_code_valid_q, operand_valid_q;
    logic read_type, operand_edge;
    logic [7:0] status_byte;

    assign read_type = op_code_i inside {OP_STATUS, OP_READ, OP_METERING};
    assign operand_edge = operand_valid_i && !operand_valid_q;

    always_comb begin
        status_byte = '0;
        status_byte[STATUS_BUSY_BIT] = capture_busy_i;
        status_byte[STATUS_DONE_BIT] = capture_done_i;
    end

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            op_code_valid_q <= 1'b0;
            operand_valid_q <= 1'b0;
            capture_request_o <= 1'b0;
            read_address_o <= '0;
            response_valid_o <= 1'b0;
        end else begin
            op_code_valid_q <= op_code_valid_i;
            operand_valid_q <= operand_valid_i;
            // One pulse per capture transaction
            capture_request_o <= op_code_valid_i && !op_code_valid_q
                                 && op_code_i == OP_CAPTURE;
            response_valid_o <= op_code_valid_i && read_type;

            if (capture_request_o) begin
                read_address_o <= '0;  // Readback restarts at byte 0
            end else if (op_code_valid_i && op_code_i == OP_READ && operand_edge) begin
                read_address_o <= read_address_o + 1'b1;
            end
        end
    end

    always_ff @(posedge clock_spi_in) begin
        if (op_code_valid_i) begin
            case (op_code_i)
                OP_STATUS: response_o <= status_byte;
                OP_READ: response_o <= read_byte_i;  // Tracks the buffer output
                OP_METERING: begin
                    case (operand_count_i)
                        0: response_o <= red_level_i;
                        1: response_o <= green_level_i;
                        2: response_o <= blue_level_i;
                        default: response_o <= '0;
                    endcase
                end
                default: ;
            endcase
        end
    end

endmodule

/* logic/frame_capture.sv */
// Stores one cropped frame per capture request into the image buffer
// Kept pixels are cut to 8 bits and packed four to a word, lane 0 first
`timescale 1ns/1ps

module frame_capture import camera_pkg::*; #(
    parameter int BUFFER_WORDS = 16384,
    localparam int ADDR_WIDTH = $clog2(BUFFER_WORDS)
) (
    input  logic                   clock_spi_in,
    input  logic                   mipi_byte_reset_n,
    input  logic                   capture_request_i,
    input  logic [PIXEL_WIDTH-1:0] pixel_i,
    input  logic                   pixel_valid_i,
    input  logic                   frame_valid_i,
    output logic                   capture_busy_o,
    output logic                   capture_done_o,
    output logic                   write_enable_o,
    output logic [ADDR_WIDTH-1:0]  write_address_o,
    output logic [31:0]            write_data_o
);

    localparam logic [1:0] IDLE = 2'd0;
    localparam logic [1:0] WAIT_FRAME = 2'd1;
    localparam logic [1:0] STORE = 2'd2;

    logic [1:0] state_q;
    logic frame_valid_q, finish_q;
    logic [1:0] lane_q;
    logic [ADDR_WIDTH:0] word_count_q;  // Saturates at BUFFER_WORDS
    logic [31:0] word_q;
    logic [7:0] pixel_byte;
    logic frame_start, frame_end, take_pixel, word_full, in_range;

    assign pixel_byte = pixel_i[PIXEL_WIDTH-1 -: 8];
    assign frame_start = frame_valid_i && !frame_valid_q;
    assign frame_end = state_q == STORE && frame_valid_q && !frame_valid_i;
    assign take_pixel = pixel_valid_i
                        && (state_q == STORE || (state_q == WAIT_FRAME && frame_start));
    assign word_full = take_pixel && lane_q == 2'd3;
    assign in_range = word_count_q < BUFFER_WORDS;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            state_q <= IDLE;
            frame_valid_q <= 1'b0;
            finish_q <= 1'b0;
            lane_q <= '0;
            word_count_q <= '0;
            write_enable_o <= 1'b0;
            capture_busy_o <= 1'b0;
            capture_done_o <= 1'b0;
        end else begin
            frame_valid_q <= frame_valid_i;
            finish_q <= frame_end;  // Done follows the flush write
            write_enable_o <= (word_full || (frame_end && lane_q != 2'd0)) && in_range;
            if (capture_request_i) begin
                state_q <= WAIT_FRAME;
                lane_q <= '0;
                word_count_q <= '0;
                capture_busy_o <= 1'b1;
                capture_done_o <= 1'b0;
            end else begin
                if (state_q == WAIT_FRAME && frame_start) state_q <= STORE;
                if (frame_end) state_q <= IDLE;
                if (take_pixel) lane_q <= lane_q + 1'b1;
                if (word_full && in_range) word_count_q <= word_count_q + 1'b1;
                if (finish_q) begin
                    capture_busy_o <= 1'b0;
                    capture_done_o <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock_spi_in) begin
        write_address_o <= word_count_q[ADDR_WIDTH-1:0];
        if (capture_request_i) begin
            word_q <= '0;
        end else if (word_full) begin
            write_data_o <= {pixel_byte, word_q[23:0]};
            word_q <= '0;
        end else if (take_pixel) begin
            word_q[lane_q*8 +: 8] <= pixel_byte;
        end else if (frame_end) begin
            write_data_o <= word_q;  // Partial word with upper lanes still zero
            word_q <= '0;
        end
    end

endmodule

/* logic/image_buffer.sv */
// On-chip frame store, written a 32-bit word at a time
// Read side takes a byte address and returns that lane one cycle later
`timescale 1ns/1ps

module image_buffer #(
    parameter int BUFFER_WORDS = 16384,
    localparam int ADDR_WIDTH = $clog2(BUFFER_WORDS)
) (
    input  logic                  clock_spi_in,
    input  logic                  write_enable_i,
    input  logic [ADDR_WIDTH-1:0] write_address_i,
    input  logic [31:0]           write_data_i,
    input  logic [ADDR_WIDTH+1:0] read_address_i,
    output logic [7:0]            read_byte_o
);

    logic [31:0] memory [BUFFER_WORDS];
    logic [31:0] read_word;

    assign read_word = memory[read_address_i[ADDR_WIDTH+1:2]];

    always_ff @(posedge clock_spi_in) begin
        if (write_enable_i) memory[write_address_i] <= write_data_i;
        read_byte_o <= read_word[read_address_i[1:0]*8 +: 8];  // Lane select
    end

endmodule

/* logic/pixel_crop.sv */
// Passes only the pixels that fall inside the crop window
// Output is one cycle behind the input stream, frame_valid delayed to match
`timescale 1ns/1ps

module pixel_crop import camera_pkg::*; (
    input  logic                   clock_spi_in,
    input  logic                   mipi_byte_reset_n,
    input  logic [PIXEL_WIDTH-1:0] pixel_data_i,
    input  logic                   line_valid_i,
    input  logic                   frame_valid_i,
    input  logic [X_WIDTH-1:0]     crop_x_start_i,
    input  logic [X_WIDTH-1:0]     crop_x_end_i,
    input  logic [Y_WIDTH-1:0]     crop_y_start_i,
    input  logic [Y_WIDTH-1:0]     crop_y_end_i,
    output logic [PIXEL_WIDTH-1:0] pixel_o,
    output logic                   pixel_valid_o,
    output logic                   frame_valid_o
);

    logic [X_WIDTH-1:0] x_count;
    logic [Y_WIDTH-1:0] y_count;
    logic line_valid_q;
    logic pixel_present, in_window;

    assign pixel_present = frame_valid_i && line_valid_i;
    assign in_window = x_count >= crop_x_start_i && x_count < crop_x_end_i
                       && y_count >= crop_y_start_i && y_count < crop_y_end_i;

    always_ff @(posedge clock_spi_in or negedge mipi_byte_reset_n) begin
        if (!mipi_byte_reset_n) begin
            x_count <= '0;
            y_count <= '0;
            line_valid_q <= 1'b0;
            pixel_valid_o <= 1'b0;
            frame_valid_o <= 1'b0;
        end else begin
            line_valid_q <= line_valid_i;
            frame_valid_o <= frame_valid_i;
            pixel_valid_o <= pixel_present && in_window;

            if (!line_valid_i) x_count <= '0;
            else if (pixel_present) x_count <= x_count + 1'b1;

            if (!frame_valid_i) y_count <= '0;
            else if (line_valid_q && !line_valid_i) y_count <= y_count + 1'b1;  // Line end
        end
    end

    always_ff @(posedge clock_spi_in) begin
        pixel_o <= pixel_data_i;
    end

endmodule

/* project.f */
logic/camera_pkg.sv
logic/camera_regs.sv
logic/pixel_crop.sv
logic/color_metering.sv
logic/frame_capture.sv
logic/image_buffer.sv
logic/command_decoder.sv
logic/camera.sv
verification/camera_tb.sv

/* verification/camera_tb.sv */
// Testbench for the camera still-capture path
// Streams synthetic 32x24 Bayer frames, drives host commands and checks
// readback bytes, status and metering levels against reference functions
`timescale 1ns/1ps

module camera_tb import camera_pkg::*;;

    localparam int CLOCK_PERIOD = 40;
    localparam int FRAME_CYCLES = 1000;  // One frame period, rounded up
    localparam int WIDTH = 32;
    localparam int HEIGHT = 24;
    localparam int METER_START = 8;
    localparam int METER_LOG2 = 3;

    logic clock_spi_in;
    logic mipi_byte_reset_n;
    logic frame_valid_i, line_valid_i;
    logic [PIXEL_WIDTH-1:0] pixel_data_i;
    logic [7:0] op_code_i, operand_i;
    logic op_code_valid_i, operand_valid_i;
    int operand_count_i;
    logic [7:0] response_o;
    logic response_valid_o;

    int error_count = 0;
    int test_start_errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    camera #(
        .CROP_X_START_RESET(11'd0),
        .CROP_X_END_RESET(11'd16),
        .CROP_Y_START_RESET(10'd0),
        .CROP_Y_END_RESET(10'd8),
        .BUFFER_WORDS(64),
        .METER_X_START(11'd8),
        .METER_Y_START(10'd8),
        .METER_SIZE_LOG2(METER_LOG2)
    ) DUT (
        .clock_spi_in(clock_spi_in),
        .mipi_byte_reset_n(mipi_byte_reset_n),
        .frame_valid_i(frame_valid_i),
        .line_valid_i(line_valid_i),
        .pixel_data_i(pixel_data_i),
        .op_code_i(op_code_i),
        .op_code_valid_i(op_code_valid_i),
        .operand_i(operand_i),
        .operand_valid_i(operand_valid_i),
        .operand_count_i(operand_count_i),
        .response_o(response_o),
        .response_valid_o(response_valid_o)
    );

    initial begin
        clock_spi_in = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock_spi_in = ~clock_spi_in;
    end

    // Twenty frame periods is well beyond the longest test sequence
    initial begin
        #(20 * FRAME_CYCLES * CLOCK_PERIOD);
        $display("Timeout: the tests did not finish within 20 frame periods");
        $display("SOME TESTS FAILED");
        $finish;
    end

    function automatic logic [9:0] pixel_value(int x, int y, int base);
        return (3 * x + 5 * y + base) % 1024;
    endfunction

    // Byte at a given readback index for a crop window in raster order
    function automatic logic [7:0] expected_byte(int index, int base, int x0, int x1,
                                                 int y0, int y1);
        int width;
        logic [9:0] value;
        width = x1 - x0;
        value = pixel_value(x0 + index % width, y0 + index / width, base);
        return value[9:2];
    endfunction

    // Returns {red, green, blue} averages over the RGGB metering window
    function automatic logic [23:0] expected_levels(int base);
        int red_sum, green_sum, blue_sum, x, y;
        logic [9:0] value;
        red_sum = 0;
        green_sum = 0;
        blue_sum = 0;
        for (y = METER_START; y < METER_START + (1 << METER_LOG2); y++) begin
            for (x = METER_START; x < METER_START + (1 << METER_LOG2); x++) begin
                value = pixel_value(x, y, base);
                if (x % 2 == 0 && y % 2 == 0) red_sum += value[9:2];
                else if (x % 2 == 1 && y % 2 == 1) blue_sum += value[9:2];
                else green_sum += value[9:2];
            end
        end
        return {8'((red_sum >> (2 * METER_LOG2 - 2)) & 255),
                8'((green_sum >> (2 * METER_LOG2 - 1)) & 255),
                8'((blue_sum >> (2 * METER_LOG2 - 2)) & 255)};
    endfunction

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("Fail %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic end_test(string name);
        if (error_count == test_start_errors) begin
            tests_passed++;
            $display("Test %s: pass", name);
        end else begin
            tests_failed++;
            $display("Test %s: fail", name);
        end
        test_start_errors = error_count;
    endtask

    task automatic send_frame(int base);
        for (int y = 0; y < HEIGHT; y++) begin
            for (int x = 0; x < WIDTH; x++) begin
                @(posedge clock_spi_in);
                frame_valid_i <= 1'b1;
                line_valid_i <= 1'b1;
                pixel_data_i <= pixel_value(x, y, base);
            end
            repeat (y == HEIGHT - 1 ? 0 : 4) begin  // Line blanking
                @(posedge clock_spi_in);
                line_valid_i <= 1'b0;
            end
        end
        repeat (20) begin
            @(posedge clock_spi_in);
            frame_valid_i <= 1'b0;
            line_valid_i <= 1'b0;
        end
    endtask

    task automatic begin_op(logic [7:0] op, int count);
        @(posedge clock_spi_in);
        op_code_i <= op;
        op_code_valid_i <= 1'b1;
        operand_count_i <= count;
    endtask

    task automatic end_op();
        @(posedge clock_spi_in);
        op_code_valid_i <= 1'b0;
        @(posedge clock_spi_in);
    endtask

    task automatic pulse_operand(logic [7:0] value, int count);
        @(posedge clock_spi_in);
        operand_i <= value;
        operand_count_i <= count;
        operand_valid_i <= 1'b1;
        @(posedge clock_spi_in);
        operand_valid_i <= 1'b0;
    endtask

    // Host waits three cycles after the last change before sampling
    task automatic sample_response(output logic [7:0] value);
        repeat (3) @(posedge clock_spi_in);
        @(negedge clock_spi_in);
        check_value("response_valid_o", response_valid_o, 1'b1);
        value = response_o;
    endtask

    task automatic query(logic [7:0] op, int count, output logic [7:0] value);
        begin_op(op, count);
        sample_response(value);
        end_op();
    endtask

    task automatic capture();
        begin_op(OP_CAPTURE, 0);
        end_op();
    endtask

    task automatic write_crop(logic [7:0] op, logic [15:0] value);
        begin_op(op, 0);
        pulse_operand(value[7:0], 0);
        pulse_operand(value[15:8], 1);
        end_op();
    endtask

    task automatic wait_done();
        logic [7:0] status;
        int polls;
        status = '0;
        polls = 0;
        while (!status[STATUS_DONE_BIT] && polls < 50) begin
            query(OP_STATUS, 0, status);
            polls++;
        end
        if (!status[STATUS_DONE_BIT]) begin
            error_count++;
            $display("Capture never reported done after %0d status polls", polls);
        end
        check_value("status", status, 32'(1 << STATUS_DONE_BIT));
    endtask

    task automatic read_image(int base, int x0, int x1, int y0, int y1);
        logic [7:0] value;
        begin_op(OP_READ, 0);
        sample_response(value);
        check_value("response_o", value, expected_byte(0, base, x0, x1, y0, y1));
        for (int i = 1; i < 128; i++) begin
            pulse_operand(8'h00, 0);
            sample_response(value);
            check_value("response_o", value, expected_byte(i, base, x0, x1, y0, y1));
        end
        end_op();
    endtask

    initial begin
        int base_a, base_b;
        logic [7:0] value;
        logic [23:0] levels;
        void'($urandom(32'ha733_ad0f));
        mipi_byte_reset_n <= 1'b0;
        frame_valid_i <= 1'b0;
        line_valid_i <= 1'b0;
        pixel_data_i <= '0;
        op_code_i <= '0;
        op_code_valid_i <= 1'b0;
        operand_i <= '0;
        operand_valid_i <= 1'b0;
        operand_count_i <= 0;
        repeat (5) @(posedge clock_spi_in);
        mipi_byte_reset_n <= 1'b1;

        repeat (4) begin
            @(negedge clock_spi_in);
            check_value("response_valid_o", response_valid_o, 1'b0);
        end
        query(OP_STATUS, 0, value);
        check_value("status", value, 0);
        end_test("reset status");

        base_a = $urandom % 1024;
        capture();
        query(OP_STATUS, 0, value);
        check_value("status", value, 32'(1 << STATUS_BUSY_BIT));
        send_frame(base_a);
        wait_done();
        read_image(base_a, 0, 16, 0, 8);
        end_test("default window capture");

        write_crop(OP_CROP_X_START, 16'd4);
        write_crop(OP_CROP_X_END, 16'd20);
        write_crop(OP_CROP_Y_START, 16'd2);
        write_crop(OP_CROP_Y_END, 16'd10);
        base_a = $urandom % 1024;
        capture();
        send_frame(base_a);
        wait_done();
        read_image(base_a, 4, 20, 2, 10);
        end_test("crop window capture");

        // New window written while the captured frame streams
        base_a = $urandom % 1024;
        capture();
        fork
            send_frame(base_a);
            begin
                repeat (100) @(posedge clock_spi_in);
                write_crop(OP_CROP_X_START, 16'd0);
                write_crop(OP_CROP_X_END, 16'd16);
                write_crop(OP_CROP_Y_START, 16'd0);
                write_crop(OP_CROP_Y_END, 16'd8);
            end
        join
        wait_done();
        read_image(base_a, 4, 20, 2, 10);
        end_test("mid-frame crop write");

        base_a = $urandom % 1024;
        base_b = $urandom % 1024;
        fork
            send_frame(base_a);
            begin
                repeat (300) @(posedge clock_spi_in);
                capture();
            end
        join
        send_frame(base_b);
        wait_done();
        read_image(base_b, 0, 16, 0, 8);
        end_test("mid-frame capture request");

        levels = expected_levels(base_b);
        query(OP_METERING, 0, value);
        check_value("red_level", value, levels[23:16]);
        query(OP_METERING, 1, value);
        check_value("green_level", value, levels[15:8]);
        query(OP_METERING, 2, value);
        check_value("blue_level", value, levels[7:0]);
        end_test("metering levels");

        $display("Tests passed %0d, failed %0d, errors %0d",
                 tests_passed, tests_failed, error_count);
        if (tests_failed == 0 && error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
